// ==== Makefile ====
.PHONY: all lint clean

all:
	verilator --binary --timing -f project.f --top-module lsuTb -o VlsuTb
	out=$$(./obj_dir/VlsuTb); echo "$$out"; echo "$$out" | grep -q "=== PASS ==="

lint:
	verilator --lint-only --timing -f project.f --top-module lsuTb

clean:
	rm -rf obj_dir

// ==== hdl/dataMemory.sv ====
`timescale 1ns/10ps
`include "lsu_settings.svh"

module dataMemory import lsuPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       memReq,
    input  logic       memWrite,
    input  dataT       memAddr,
    input  dataT       memWdata,
    input  accessSizeT memSize,
    output dataT       rdData
);

    localparam int AddrW = $clog2(`LSU_MEM_WORDS);

    dataT               mem [`LSU_MEM_WORDS];
    logic [AddrW-1:0]   wordIdx;
    logic [3:0]         byteEn;
    dataT               wdataRep;

    // address wraps at the memory size
    assign wordIdx = memAddr[AddrW+1:2];

    // lanes touched by the access
    always_comb begin
        case (memSize)
            sizeByte: begin
                byteEn   = 4'b0001 << memAddr[1:0];
                wdataRep = {4{memWdata[7:0]}};
            end
            sizeHalf: begin
                byteEn   = 4'b0011 << {memAddr[1], 1'b0};
                wdataRep = {2{memWdata[15:0]}};
            end
            default: begin
                byteEn   = 4'b1111;
                wdataRep = memWdata;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int w = 0; w < `LSU_MEM_WORDS; w++) begin
                mem[w] <= '0;
            end
            rdData <= '0;
        end else if (memReq) begin
            if (memWrite) begin
                for (int b = 0; b < 4; b++) begin
                    if (byteEn[b]) begin
                        mem[wordIdx][b*8 +: 8] <= wdataRep[b*8 +: 8];
                    end
                end
            end else begin
                // whole word, lane picked later
                rdData <= mem[wordIdx];
            end
        end
    end

endmodule

// ==== hdl/loadStoreBuffer.sv ====
`timescale 1ns/10ps
`include "lsu_settings.svh"

module loadStoreBuffer import lsuPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       flush,
    input  logic       dpValid,
    input  nickT       dpNick,
    input  nickT       dpRs1Nick,
    input  dataT       dpRs1Data,
    input  nickT       dpRs2Nick,
    input  dataT       dpRs2Data,
    input  dataT       dpImm,
    input  logic       isMem,
    input  lsKindT     kind,
    input  accessSizeT size,
    input  logic       isSigned,
    input  logic       exValid,
    input  nickT       exNick,
    input  dataT       exData,
    input  logic       cdbValid,
    input  nickT       cdbNick,
    input  dataT       cdbData,
    input  logic       commitValid,
    input  nickT       commitNick,
    output logic       memReq,
    output logic       memWrite,
    output dataT       memAddr,
    output dataT       memWdata,
    output accessSizeT memSize,
    output nickT       reqNick,
    output logic       reqSigned,
    output logic       reqWrite
);

    localparam int Depth = 1 << `LSU_NICK_W;

    // entry control
    logic [Depth-1:0] valid;
    logic [Depth-1:0] issued;
    logic [Depth-1:0] rs1Ready;
    logic [Depth-1:0] rs2Ready;

    // entry payload
    lsKindT           kindQ    [Depth];
    accessSizeT       sizeQ    [Depth];
    logic [Depth-1:0] signedQ;
    dataT             immQ     [Depth];
    nickT             rs1NickQ [Depth];
    nickT             rs2NickQ [Depth];
    dataT             rs1Data  [Depth];
    dataT             rs2Data  [Depth];

    logic dpTake;
    logic storeGo;
    logic loadGo;
    nickT loadSel;
    nickT issueNick;
    logic commitPend;
    nickT commitSlot;

    // either broadcast carries this nick now
    function automatic logic busHit(nickT n);
        return (exValid && exNick == n) || (cdbValid && cdbNick == n);
    endfunction

    function automatic dataT busData(nickT n);
        return (exValid && exNick == n) ? exData : cdbData;
    endfunction

    assign dpTake = dpValid && isMem && (dpNick != '0);

    // committed store first, else lowest ready load
    always_comb begin
        storeGo = commitPend && valid[commitSlot] && (kindQ[commitSlot] == kindStore)
                  && rs1Ready[commitSlot] && rs2Ready[commitSlot];
        loadGo  = 1'b0;
        loadSel = '0;
        for (int i = Depth - 1; i > 0; i--) begin
            if (valid[i] && !issued[i] && (kindQ[i] == kindLoad) && rs1Ready[i]) begin
                loadGo  = 1'b1;
                loadSel = nickT'(i);
            end
        end
    end

    assign issueNick = storeGo ? commitSlot : loadSel;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            valid      <= '0;
            issued     <= '0;
            rs1Ready   <= '0;
            rs2Ready   <= '0;
            memReq     <= 1'b0;
            commitPend <= 1'b0;
        end else if (flush) begin
            valid      <= '0;
            issued     <= '0;
            memReq     <= 1'b0;
            commitPend <= 1'b0;
        end else begin
            memReq     <= storeGo || loadGo;
            commitPend <= commitValid;
            for (int i = 1; i < Depth; i++) begin
                if (valid[i] && !rs1Ready[i] && busHit(rs1NickQ[i])) begin
                    rs1Ready[i] <= 1'b1;
                end
                if (valid[i] && !rs2Ready[i] && busHit(rs2NickQ[i])) begin
                    rs2Ready[i] <= 1'b1;
                end
            end
            // a load leaves when its own result comes back
            if (cdbValid && issued[cdbNick]) begin
                valid[cdbNick]  <= 1'b0;
                issued[cdbNick] <= 1'b0;
            end
            if (storeGo) begin
                valid[commitSlot] <= 1'b0;
            end else if (loadGo) begin
                issued[loadSel] <= 1'b1;
            end
            if (dpTake) begin
                valid[dpNick]    <= 1'b1;
                issued[dpNick]   <= 1'b0;
                rs1Ready[dpNick] <= (dpRs1Nick == '0) || busHit(dpRs1Nick);
                rs2Ready[dpNick] <= (dpRs2Nick == '0) || busHit(dpRs2Nick);
            end
        end
    end

    always_ff @(posedge clk) begin
        // commit is registered before the store issues
        commitSlot <= commitNick;
        for (int i = 1; i < Depth; i++) begin
            if (!rs1Ready[i] && busHit(rs1NickQ[i])) begin
                rs1Data[i] <= busData(rs1NickQ[i]);
            end
            if (!rs2Ready[i] && busHit(rs2NickQ[i])) begin
                rs2Data[i] <= busData(rs2NickQ[i]);
            end
        end
        if (dpTake) begin
            kindQ[dpNick]    <= kind;
            sizeQ[dpNick]    <= size;
            signedQ[dpNick]  <= isSigned;
            immQ[dpNick]     <= dpImm;
            rs1NickQ[dpNick] <= dpRs1Nick;
            rs2NickQ[dpNick] <= dpRs2Nick;
            rs1Data[dpNick]  <= (dpRs1Nick == '0) ? dpRs1Data : busData(dpRs1Nick);
            rs2Data[dpNick]  <= (dpRs2Nick == '0) ? dpRs2Data : busData(dpRs2Nick);
        end
        // request payload, qualified by memReq
        if (storeGo || loadGo) begin
            memWrite  <= storeGo;
            reqWrite  <= storeGo;
            memAddr   <= rs1Data[issueNick] + immQ[issueNick];
            memWdata  <= storeGo ? rs2Data[issueNick] : '0;
            memSize   <= sizeQ[issueNick];
            reqNick   <= issueNick;
            reqSigned <= signedQ[issueNick];
        end
    end

endmodule

// ==== hdl/lsuDecode.sv ====
`timescale 1ns/10ps
`include "lsu_settings.svh"

module lsuDecode import lsuPkg::*; (
    input  lsuOpT      op,
    output logic       isMem,
    output lsKindT     kind,
    output accessSizeT size,
    output logic       isSigned
);

    always_comb begin
        isMem    = 1'b1;
        kind     = kindLoad;
        size     = sizeWord;
        isSigned = 1'b0;
        case (op)
            opLb: begin
                size     = sizeByte;
                isSigned = 1'b1;
            end
            opLh: begin
                size     = sizeHalf;
                isSigned = 1'b1;
            end
            opLw: begin
                size = sizeWord;
            end
            opLbu: begin
                size = sizeByte;
            end
            opLhu: begin
                size = sizeHalf;
            end
            opSb: begin
                kind = kindStore;
                size = sizeByte;
            end
            opSh: begin
                kind = kindStore;
                size = sizeHalf;
            end
            opSw: begin
                kind = kindStore;
                size = sizeWord;
            end
            // anything else never enters the buffer
            default: isMem = 1'b0;
        endcase
    end

endmodule

// ==== hdl/lsuPkg.sv ====
`include "lsu_settings.svh"

package lsuPkg;

    // reorder tag, 0 means no dependency
    typedef logic [`LSU_NICK_W-1:0] nickT;

    typedef logic [`LSU_DATA_W-1:0] dataT;

    // dispatched opcodes seen by the buffer
    typedef enum logic [3:0] {
        opLb    = 4'h0,
        opLh    = 4'h1,
        opLw    = 4'h2,
        opLbu   = 4'h3,
        opLhu   = 4'h4,
        opSb    = 4'h5,
        opSh    = 4'h6,
        opSw    = 4'h7,
        opOther = 4'hf
    } lsuOpT;

    typedef enum logic [1:0] {
        sizeByte = 2'd0,
        sizeHalf = 2'd1,
        sizeWord = 2'd2
    } accessSizeT;

    typedef enum logic {
        kindLoad  = 1'b0,
        kindStore = 1'b1
    } lsKindT;

endpackage

// ==== hdl/lsuResult.sv ====
`timescale 1ns/10ps
`include "lsu_settings.svh"

module lsuResult import lsuPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       flush,
    input  logic       memReq,
    input  logic [1:0] memAddrLo,
    input  accessSizeT memSize,
    input  nickT       reqNick,
    input  logic       reqSigned,
    input  logic       reqWrite,
    input  dataT       rdData,
    output logic       cdbValid,
    output nickT       cdbNick,
    output dataT       cdbData
);

    // request attributes lined up with rdData
    logic       pendValid;
    logic [1:0] pendLo;
    accessSizeT pendSize;
    nickT       pendNick;
    logic       pendSigned;
    logic       pendWrite;

    logic [7:0]  byteLane;
    logic [15:0] halfLane;
    dataT        loadData;

    assign byteLane = rdData[pendLo*8 +: 8];
    assign halfLane = rdData[pendLo[1]*16 +: 16];

    always_comb begin
        case (pendSize)
            sizeByte: loadData = {{(`LSU_DATA_W-8){pendSigned & byteLane[7]}}, byteLane};
            sizeHalf: loadData = {{(`LSU_DATA_W-16){pendSigned & halfLane[15]}}, halfLane};
            default:  loadData = rdData;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pendValid <= 1'b0;
            cdbValid  <= 1'b0;
        end else if (flush) begin
            pendValid <= 1'b0;
            cdbValid  <= 1'b0;
        end else begin
            pendValid <= memReq;
            cdbValid  <= pendValid;
        end
    end

    always_ff @(posedge clk) begin
        pendLo     <= memAddrLo;
        pendSize   <= memSize;
        pendNick   <= reqNick;
        pendSigned <= reqSigned;
        pendWrite  <= reqWrite;
        cdbNick    <= pendNick;
        // stores complete with zero data
        cdbData    <= pendWrite ? '0 : loadData;
    end

endmodule

// ==== hdl/lsuTop.sv ====
`timescale 1ns/10ps
`include "lsu_settings.svh"

module lsuTop import lsuPkg::*; (
    input  logic  clk,
    input  logic  rstN,
    input  logic  dpValid,
    input  lsuOpT dpOp,
    input  nickT  dpNick,
    input  nickT  dpRs1Nick,
    input  dataT  dpRs1Data,
    input  nickT  dpRs2Nick,
    input  dataT  dpRs2Data,
    input  dataT  dpImm,
    input  logic  exValid,
    input  nickT  exNick,
    input  dataT  exData,
    input  logic  commitValid,
    input  nickT  commitNick,
    input  logic  flush,
    output logic  cdbValid,
    output nickT  cdbNick,
    output dataT  cdbData
);

    logic       isMem;
    lsKindT     kind;
    accessSizeT size;
    logic       isSigned;

    logic       memReq;
    logic       memWrite;
    dataT       memAddr;
    dataT       memWdata;
    accessSizeT memSize;
    nickT       reqNick;
    logic       reqSigned;
    logic       reqWrite;
    dataT       rdData;

    lsuDecode lsuDecode_inst (
        .op       (dpOp),
        .isMem    (isMem),
        .kind     (kind),
        .size     (size),
        .isSigned (isSigned)
    );

    // cdb loops back for wakeup and load release
    loadStoreBuffer loadStoreBuffer_inst (
        .clk         (clk),
        .rstN        (rstN),
        .flush       (flush),
        .dpValid     (dpValid),
        .dpNick      (dpNick),
        .dpRs1Nick   (dpRs1Nick),
        .dpRs1Data   (dpRs1Data),
        .dpRs2Nick   (dpRs2Nick),
        .dpRs2Data   (dpRs2Data),
        .dpImm       (dpImm),
        .isMem       (isMem),
        .kind        (kind),
        .size        (size),
        .isSigned    (isSigned),
        .exValid     (exValid),
        .exNick      (exNick),
        .exData      (exData),
        .cdbValid    (cdbValid),
        .cdbNick     (cdbNick),
        .cdbData     (cdbData),
        .commitValid (commitValid),
        .commitNick  (commitNick),
        .memReq      (memReq),
        .memWrite    (memWrite),
        .memAddr     (memAddr),
        .memWdata    (memWdata),
        .memSize     (memSize),
        .reqNick     (reqNick),
        .reqSigned   (reqSigned),
        .reqWrite    (reqWrite)
    );

    dataMemory dataMemory_inst (
        .clk      (clk),
        .rstN     (rstN),
        .memReq   (memReq),
        .memWrite (memWrite),
        .memAddr  (memAddr),
        .memWdata (memWdata),
        .memSize  (memSize),
        .rdData   (rdData)
    );

    lsuResult lsuResult_inst (
        .clk       (clk),
        .rstN      (rstN),
        .flush     (flush),
        .memReq    (memReq),
        .memAddrLo (memAddr[1:0]),
        .memSize   (memSize),
        .reqNick   (reqNick),
        .reqSigned (reqSigned),
        .reqWrite  (reqWrite),
        .rdData    (rdData),
        .cdbValid  (cdbValid),
        .cdbNick   (cdbNick),
        .cdbData   (cdbData)
    );

endmodule

// ==== include/lsu_settings.svh ====
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// nick width, buffer depth is 2**LSU_NICK_W with slot 0 unused
`define LSU_NICK_W 4

// data and address width
`define LSU_DATA_W 32

// data memory size in 32-bit words
`define LSU_MEM_WORDS 256

`endif

// ==== project.f ====
+incdir+include
hdl/lsuPkg.sv
hdl/lsuDecode.sv
hdl/loadStoreBuffer.sv
hdl/dataMemory.sv
hdl/lsuResult.sv
hdl/lsuTop.sv
verification/lsu_assertions.sv
verification/lsuTb.sv

// ==== verification/lsuTb.sv ====
`timescale 1ns/10ps
`include "lsu_settings.svh"

module lsuTb import lsuPkg::*; ;

    localparam int MemBytes = `LSU_MEM_WORDS * 4;
    localparam int Slots = 1 << `LSU_NICK_W;
    // drive edge, sample edge, three pipeline cycles, seen one edge later
    localparam int SeenLatency = 5;
    localparam int WaitLimit = 50;

    logic  clk = 1'b0;
    logic  rstN;
    logic  dpValid;
    lsuOpT dpOp;
    nickT  dpNick;
    nickT  dpRs1Nick;
    dataT  dpRs1Data;
    nickT  dpRs2Nick;
    dataT  dpRs2Data;
    dataT  dpImm;
    logic  exValid;
    nickT  exNick;
    dataT  exData;
    logic  commitValid;
    nickT  commitNick;
    logic  flush;
    logic  cdbValid;
    nickT  cdbNick;
    dataT  cdbData;

    // reference model state
    logic [7:0] refMem [MemBytes];
    dataT       knownVal [Slots];
    logic [3:0] opQ [Slots];
    nickT       baseNickQ [Slots];
    dataT       baseQ [Slots];
    dataT       immQ [Slots];
    nickT       dataNickQ [Slots];
    dataT       dataQ [Slots];
    int         startCycle [Slots];
    logic       timed [Slots];

    // every broadcast seen, in order
    nickT seenNick [$];
    dataT seenData [$];
    int   seenCycle [$];
    int   cycles = 0;

    always #5 clk = ~clk;

    lsuTop lsuTop_inst (
        .clk         (clk),
        .rstN        (rstN),
        .dpValid     (dpValid),
        .dpOp        (dpOp),
        .dpNick      (dpNick),
        .dpRs1Nick   (dpRs1Nick),
        .dpRs1Data   (dpRs1Data),
        .dpRs2Nick   (dpRs2Nick),
        .dpRs2Data   (dpRs2Data),
        .dpImm       (dpImm),
        .exValid     (exValid),
        .exNick      (exNick),
        .exData      (exData),
        .commitValid (commitValid),
        .commitNick  (commitNick),
        .flush       (flush),
        .cdbValid    (cdbValid),
        .cdbNick     (cdbNick),
        .cdbData     (cdbData)
    );

    bind lsuTop lsuAssertions lsuAssertions_inst (
        .clk      (clk),
        .rstN     (rstN),
        .flush    (flush),
        .memReq   (memReq),
        .cdbValid (cdbValid),
        .cdbNick  (cdbNick)
    );

    always @(posedge clk) begin
        if (rstN && cdbValid) begin
            seenNick.push_back(cdbNick);
            seenData.push_back(cdbData);
            seenCycle.push_back(cycles);
        end
        cycles <= cycles + 1;
    end

    task automatic reportFailure(string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkValue(string name, dataT expected, dataT actual);
        if (expected !== actual) begin
            reportFailure($sformatf("FAIL %s: expected %h, got %h", name, expected, actual));
        end
    endtask

    function automatic dataT addrOf(nickT n);
        return ((baseNickQ[n] == '0) ? baseQ[n] : knownVal[baseNickQ[n]]) + immQ[n];
    endfunction

    // lane pick and extension straight from the byte image
    function automatic dataT expectedLoad(nickT n);
        int         a;
        logic [7:0] b;
        logic [15:0] h;
        a = int'(addrOf(n) & dataT'(MemBytes - 1));
        b = refMem[a];
        case (lsuOpT'(opQ[n]))
            opLb:    return {{24{b[7]}}, b};
            opLbu:   return {24'h0, b};
            opLh: begin
                h = {refMem[a + 1], refMem[a]};
                return {{16{h[15]}}, h};
            end
            opLhu: begin
                h = {refMem[a + 1], refMem[a]};
                return {16'h0, h};
            end
            default: return {refMem[a + 3], refMem[a + 2], refMem[a + 1], refMem[a]};
        endcase
    endfunction

    function automatic void storeToRef(nickT n);
        int   a;
        dataT d;
        a = int'(addrOf(n) & dataT'(MemBytes - 1));
        d = (dataNickQ[n] == '0) ? dataQ[n] : knownVal[dataNickQ[n]];
        refMem[a] = d[7:0];
        if (lsuOpT'(opQ[n]) != opSb) begin
            refMem[a + 1] = d[15:8];
        end
        if (lsuOpT'(opQ[n]) == opSw) begin
            refMem[a + 2] = d[23:16];
            refMem[a + 3] = d[31:24];
        end
    endfunction

    task automatic dispatch(dataT op, dataT n, dataT r1n, dataT r1d, dataT r2n, dataT r2d,
                            dataT imm);
        nickT k;
        dataT storeData;
        k = nickT'(n);
        // store data comes from the generator unless it waits on a nick
        storeData = (r2n == 0) ? dataT'($urandom) : r2d;
        opQ[k]       = op[3:0];
        baseNickQ[k] = nickT'(r1n);
        baseQ[k]     = r1d;
        immQ[k]      = imm;
        dataNickQ[k] = nickT'(r2n);
        dataQ[k]     = storeData;
        timed[k]     = (r1n == 0) && (op[3:0] <= 4'h4);
        @(posedge clk);
        startCycle[k] = cycles;
        dpValid   <= 1'b1;
        dpOp      <= lsuOpT'(op[3:0]);
        dpNick    <= k;
        dpRs1Nick <= nickT'(r1n);
        dpRs1Data <= r1d;
        dpRs2Nick <= nickT'(r2n);
        dpRs2Data <= storeData;
        dpImm     <= imm;
        @(posedge clk);
        dpValid <= 1'b0;
    endtask

    task automatic execute(nickT k, dataT d);
        knownVal[k] = d;
        @(posedge clk);
        exValid <= 1'b1;
        exNick  <= k;
        exData  <= d;
        @(posedge clk);
        exValid <= 1'b0;
    endtask

    task automatic commit(nickT k);
        storeToRef(k);
        @(posedge clk);
        startCycle[k] = cycles;
        timed[k]      = 1'b1;
        commitValid <= 1'b1;
        commitNick  <= k;
        @(posedge clk);
        commitValid <= 1'b0;
    endtask

    // a load parked on a nick that is only broadcast after the flush
    task automatic pulseFlush();
        nickT probe;
        nickT wake;
        probe = nickT'(Slots - 1);
        wake  = nickT'(Slots - 2);
        dispatch(dataT'(opLw), dataT'(probe), dataT'(wake), '0, '0, '0, '0);
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush   <= 1'b0;
        exValid <= 1'b1;
        exNick  <= wake;
        exData  <= '0;
        @(posedge clk);
        exValid <= 1'b0;
    endtask

    task automatic expectCdb(nickT k, dataT value);
        int   waited;
        dataT got;
        int   at;
        waited = 0;
        while (seenNick.size() == 0 && waited < WaitLimit) begin
            @(posedge clk);
            waited++;
        end
        if (seenNick.size() == 0) begin
            reportFailure($sformatf("timeout: nick %h never completed", k));
        end
        checkValue("cdbNick", dataT'(k), dataT'(seenNick.pop_front()));
        got = seenData.pop_front();
        at  = seenCycle.pop_front();
        checkValue("cdbData", value, got);
        if (timed[k]) begin
            checkValue("cdbLatency", dataT'(SeenLatency), dataT'(at - startCycle[k]));
        end
        knownVal[k] = got;
    endtask

    task automatic expectQuiet(dataT count);
        repeat (count) @(posedge clk);
        if (seenNick.size() != 0) begin
            reportFailure($sformatf("unexpected result broadcast for nick %h", seenNick[0]));
        end
    endtask

    initial begin
        int    fd;
        int    cnt;
        string line;
        byte   cmd;
        dataT  f0, f1, f2, f3, f4, f5, f6;
        void'($urandom(32'h2073708a));
        rstN        = 1'b0;
        dpValid     = 1'b0;
        dpOp        = opOther;
        dpNick      = '0;
        dpRs1Nick   = '0;
        dpRs1Data   = '0;
        dpRs2Nick   = '0;
        dpRs2Data   = '0;
        dpImm       = '0;
        exValid     = 1'b0;
        exNick      = '0;
        exData      = '0;
        commitValid = 1'b0;
        commitNick  = '0;
        flush       = 1'b0;
        for (int i = 0; i < MemBytes; i++) begin
            refMem[i] = 8'h00;
        end
        for (int i = 0; i < Slots; i++) begin
            knownVal[i] = '0;
            timed[i]    = 1'b0;
        end
        repeat (10) @(posedge clk);
        rstN <= 1'b1;
        repeat (2) @(posedge clk);

        fd = $fopen("verification/lsu_tests.txt", "r");
        if (fd == 0) begin
            reportFailure("could not open verification/lsu_tests.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            cnt  = $fgets(line, fd);
            if (cnt > 0 && line.len() > 0) begin
                cmd = line.getc(0);
                f0 = '0;
                f1 = '0;
                f2 = '0;
                f3 = '0;
                f4 = '0;
                f5 = '0;
                f6 = '0;
                cnt = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h %h %h",
                              f0, f1, f2, f3, f4, f5, f6);
                case (cmd)
                    "D": dispatch(f0, f1, f2, f3, f4, f5, f6);
                    "X": execute(nickT'(f0), f1);
                    "C": commit(nickT'(f0));
                    "F": pulseFlush();
                    "E": expectCdb(nickT'(f0), f1);
                    "L": expectCdb(nickT'(f0), expectedLoad(nickT'(f0)));
                    "N": expectQuiet(f0);
                    "#", "\n", "\r", " ": ;
                    default: reportFailure($sformatf("unknown command line: %s", line));
                endcase
            end
        end
        $fclose(fd);

        repeat (5) @(posedge clk);
        if (seenNick.size() != 0) begin
            reportFailure($sformatf("result broadcast for nick %h was never expected",
                                    seenNick[0]));
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

// ==== verification/lsu_assertions.sv ====
`timescale 1ns/10ps

module lsuAssertions import lsuPkg::*; (
    input logic clk,
    input logic rstN,
    input logic flush,
    input logic memReq,
    input logic cdbValid,
    input nickT cdbNick
);

    // nick 0 is reserved for no dependency
    cdbNickNonZero: assert property (
        @(posedge clk) disable iff (!rstN)
        cdbValid |-> (cdbNick != '0)
    ) else $error("result broadcast carried nick 0");

    // flush drops the request issued alongside it
    noReqAfterFlush: assert property (
        @(posedge clk) disable iff (!rstN)
        flush |=> !memReq
    ) else $error("memory request in the cycle after flush");

    quietInReset: assert property (
        @(posedge clk)
        !rstN |-> (!memReq && !cdbValid)
    ) else $error("memory request or result broadcast during reset");

endmodule

// ==== verification/lsu_tests.txt ====
# D op nick rs1Nick rs1Data rs2Nick rs2Data imm | X nick data | C nick | F
# E nick data | L nick (value from reference memory) | N cycles
D 7 1 0 100 2 0 0
X 2 80f085a3
C 1
E 1 0
D 2 3 0 100 0 0 0
L 3
D 0 4 0 100 0 0 1
L 4
D 3 5 0 100 0 0 1
L 5
D 1 6 0 100 0 0 2
L 6
D 4 7 0 100 0 0 2
L 7
# committed byte and half stores, then merged word reads
D 5 8 0 100 0 0 3
C 8
E 8 0
D 2 9 0 100 0 0 0
L 9
D 6 a 0 200 0 0 2
C a
E a 0
D 2 b 0 200 0 0 0
L b
# store that is never committed
D 7 c 0 300 0 0 0
N 8
D 2 d 0 300 0 0 0
L d
# base waits on an execute result
D 2 e f 0 0 0 4
N 6
X f fc
L e
# flush drops the pending store
F
N a
# chained load wakes from the result broadcast
D 3 1 0 100 0 0 3
D 3 3 1 0 0 0 200
L 1
L 3
D 7 4 0 180 0 0 0
C 4
E 4 0
D 2 5 0 180 0 0 0
L 5
# non-memory opcode is ignored
D f 6 0 100 0 0 0
N 6
